//--- Bender.yml
package:
  name: mini_core

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/imm_gen.sv
      - hdl/reg_file.sv
      - hdl/exec_unit.sv
      - hdl/mini_core.sv
  - target: simulation
    files:
      - sim/tb_mini_core.sv

//--- hdl/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    // branch offset bits are scattered over the word
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_e               opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } u_fmt_t;

    // one fetched word, seen through each instruction format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  we;
        logic                  illegal;
    } retire_t;

    // per-instruction decode flags used by the execute stage
    typedef struct packed {
        logic rr_op;
        logic imm_op;
        logic lui_op;
        logic br_op;
        logic legal;
    } dec_t;

endpackage

//--- hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  instr_u                instr_i,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       imm_i,

    // register file write
    output logic                  we_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       wdata_o,

    output logic [XLEN-1:0]       next_pc_o,
    output logic                  retire_valid_o,
    output retire_t               retire_o
);

    dec_t            dec;
    logic [XLEN-1:0] result;
    logic            writes_rd;
    logic            taken;

    always_comb begin
        dec = '0;
        case (instr_i.r.opcode)
            OP: begin
                // only funct7 bit 5 may be set, it selects SUB
                dec.rr_op = (instr_i.r.funct3 == 3'b000) &&
                            !instr_i.r.funct7[6] && (instr_i.r.funct7[4:0] == '0);
            end
            OP_IMM: begin
                dec.imm_op = (instr_i.i.funct3 == 3'b000);
            end
            LUI: begin
                dec.lui_op = 1'b1;
            end
            BRANCH: begin
                // funct3 000 is BEQ, 001 is BNE
                dec.br_op = (instr_i.b.funct3[2:1] == 2'b00);
            end
            default: begin
                dec = '0;
            end
        endcase
        dec.legal = dec.rr_op | dec.imm_op | dec.lui_op | dec.br_op;
    end

    always_comb begin
        result = '0;
        if (dec.rr_op) begin
            result = instr_i.r.funct7[5] ? (rs1_data_i - rs2_data_i)
                                         : (rs1_data_i + rs2_data_i);
        end else if (dec.imm_op) begin
            result = rs1_data_i + imm_i;
        end else if (dec.lui_op) begin
            result = imm_i;
        end
    end

    assign writes_rd = dec.rr_op | dec.imm_op | dec.lui_op;
    assign taken     = dec.br_op &&
                       (instr_i.b.funct3[0] ? (rs1_data_i != rs2_data_i)
                                            : (rs1_data_i == rs2_data_i));

    assign we_o      = instr_valid_i && writes_rd;
    assign rd_o      = instr_i.r.rd;
    assign wdata_o   = result;
    assign next_pc_o = taken ? (pc_i + imm_i) : (pc_i + 32'd4);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= instr_valid_i;
        end
    end

    // retire record, captured together with the register write
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            retire_o.pc      <= pc_i;
            retire_o.rd      <= instr_i.r.rd;
            retire_o.wdata   <= result;
            retire_o.we      <= writes_rd;
            retire_o.illegal <= !dec.legal;
        end
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0
) (
    input  logic            clk_i,
    input  logic            rstn_i,

    // instruction request channel
    output logic [XLEN-1:0] ibus_req_addr_o,
    output logic            ibus_req_valid_o,
    input  logic            ibus_req_ready_i,

    // instruction response channel
    input  logic [XLEN-1:0] ibus_rsp_data_i,
    input  logic            ibus_rsp_valid_i,
    output logic            ibus_rsp_ready_o,

    // towards decode and execute
    input  logic [XLEN-1:0] next_pc_i,
    output instr_u          instr_o,
    output logic            instr_valid_o,
    output logic [XLEN-1:0] pc_o
);

    localparam logic S_REQ  = 1'b0;
    localparam logic S_WAIT = 1'b1;

    logic            state_q;
    logic [XLEN-1:0] pc_q;
    logic            req_fire;
    logic            rsp_fire;

    assign ibus_req_valid_o = (state_q == S_REQ);
    assign ibus_req_addr_o  = pc_q;
    assign ibus_rsp_ready_o = (state_q == S_WAIT);

    assign req_fire = ibus_req_valid_o && ibus_req_ready_i;
    assign rsp_fire = ibus_rsp_ready_o && ibus_rsp_valid_i;

    // the response word goes straight on to decode, no extra cycle
    assign instr_o       = ibus_rsp_data_i;
    assign instr_valid_o = rsp_fire;
    assign pc_o          = pc_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= S_REQ;
            pc_q    <= BOOT_ADDR;
        end else begin
            case (state_q)
                S_REQ: begin
                    // hold the request until the memory takes it
                    if (req_fire) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // next pc comes back from execute on the same edge
                    if (rsp_fire) begin
                        state_q <= S_REQ;
                        pc_q    <= next_pc_i;
                    end
                end
                default: begin
                    state_q <= S_REQ;
                end
            endcase
        end
    end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import core_pkg::*; (
    input  instr_u          instr_i,
    output logic [XLEN-1:0] imm_o
);

    always_comb begin
        imm_o = '0;
        case (instr_i.r.opcode)
            OP_IMM: begin
                // sign-extended 12-bit immediate
                imm_o = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            BRANCH: begin
                // 13-bit offset, always even
                imm_o = {{(XLEN-13){instr_i.b.imm_12}},
                         instr_i.b.imm_12,
                         instr_i.b.imm_11,
                         instr_i.b.imm_10_5,
                         instr_i.b.imm_4_1,
                         1'b0};
            end
            LUI: begin
                imm_o = {instr_i.u.imm, 12'b0};
            end
            default: begin
                // R-type and unknown words carry no immediate
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/mini_core.sv
`timescale 1ns/1ps

module mini_core import core_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0
) (
    input  logic            clk_i,
    input  logic            rstn_i,

    // instruction request
    output logic [XLEN-1:0] ibus_req_addr_o,
    output logic            ibus_req_valid_o,
    input  logic            ibus_req_ready_i,

    // instruction response
    input  logic [XLEN-1:0] ibus_rsp_data_i,
    input  logic            ibus_rsp_valid_i,
    output logic            ibus_rsp_ready_o,

    // retire trace
    output logic            retire_valid_o,
    output retire_t         retire_o
);

    instr_u                instr;
    logic                  instr_valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_rd;
    logic [XLEN-1:0]       rf_wdata;

    fetch_unit #(
        .BOOT_ADDR ( BOOT_ADDR )
    ) i_fetch (
        .clk_i            ( clk_i ),
        .rstn_i           ( rstn_i ),
        .ibus_req_addr_o  ( ibus_req_addr_o ),
        .ibus_req_valid_o ( ibus_req_valid_o ),
        .ibus_req_ready_i ( ibus_req_ready_i ),
        .ibus_rsp_data_i  ( ibus_rsp_data_i ),
        .ibus_rsp_valid_i ( ibus_rsp_valid_i ),
        .ibus_rsp_ready_o ( ibus_rsp_ready_o ),
        .next_pc_i        ( next_pc ),
        .instr_o          ( instr ),
        .instr_valid_o    ( instr_valid ),
        .pc_o             ( pc )
    );

    // immediate and register reads both work on the same word
    imm_gen i_imm_gen (
        .instr_i ( instr ),
        .imm_o   ( imm )
    );

    reg_file i_reg_file (
        .clk_i      ( clk_i ),
        .rstn_i     ( rstn_i ),
        .rs1_i      ( instr.r.rs1 ),
        .rs2_i      ( instr.r.rs2 ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data ),
        .we_i       ( rf_we ),
        .rd_i       ( rf_rd ),
        .wdata_i    ( rf_wdata )
    );

    exec_unit i_exec (
        .clk_i          ( clk_i ),
        .rstn_i         ( rstn_i ),
        .instr_i        ( instr ),
        .instr_valid_i  ( instr_valid ),
        .pc_i           ( pc ),
        .rs1_data_i     ( rs1_data ),
        .rs2_data_i     ( rs2_data ),
        .imm_i          ( imm ),
        .we_o           ( rf_we ),
        .rd_o           ( rf_rd ),
        .wdata_o        ( rf_wdata ),
        .next_pc_o      ( next_pc ),
        .retire_valid_o ( retire_valid_o ),
        .retire_o       ( retire_o )
    );

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    // read ports
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,

    // write port
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       wdata_i
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs_q[k] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            // x0 is never written
            regs_q[rd_i] <= wdata_i;
        end
    end

    // x0 always reads back as zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- sim/core_cases.txt
# P <word address> <instruction word>
# E <pc> <rd> <wdata> <we> <illegal>, all fields hex
P 00 00500093 # addi x1, x0, 5
P 01 ffd00113 # addi x2, x0, -3
P 02 002081b3 # add  x3, x1, x2
P 03 40110233 # sub  x4, x2, x1
P 04 800002b7 # lui  x5, 0x80000
P 05 00528333 # add  x6, x5, x5 wraps to zero
P 06 00708013 # addi x0, x1, 7
P 07 00030463 # beq  x6, x0, +8 taken, word 08 left empty
P 09 00000493 # addi x9, x0, 0
P 0a 00148493 # addi x9, x9, 1
P 0b fe149ee3 # bne  x9, x1, -4
P 0c 00248463 # beq  x9, x2, +8 not taken
P 0d 00000000 # illegal
P 0e 7ff00513 # addi x10, x0, 0x7ff
E 00 01 00000005 1 0
E 04 02 fffffffd 1 0
E 08 03 00000002 1 0
E 0c 04 fffffff8 1 0
E 10 05 80000000 1 0
E 14 06 00000000 1 0
E 18 00 0000000c 1 0
# branch rd is the offset bits in the rd slot
E 1c 08 00000000 0 0
E 24 09 00000000 1 0
E 28 09 00000001 1 0
E 2c 1d 00000000 0 0
E 28 09 00000002 1 0
E 2c 1d 00000000 0 0
E 28 09 00000003 1 0
E 2c 1d 00000000 0 0
E 28 09 00000004 1 0
E 2c 1d 00000000 0 0
E 28 09 00000005 1 0
E 2c 1d 00000000 0 0
E 30 08 00000000 0 0
E 34 00 00000000 0 1
E 38 0a 000007ff 1 0

//--- sim/tb_mini_core.sv
`timescale 1ns/1ps

module tb_mini_core import core_pkg::*; ();

    localparam int MEM_WORDS = 64;

    logic            clk_i;
    logic            rstn_i;
    logic [XLEN-1:0] ibus_req_addr_o;
    logic            ibus_req_valid_o;
    logic            ibus_req_ready_i;
    logic [XLEN-1:0] ibus_rsp_data_i;
    logic            ibus_rsp_valid_i;
    logic            ibus_rsp_ready_o;
    logic            retire_valid_o;
    retire_t         retire_o;

    logic [XLEN-1:0] mem [MEM_WORDS];
    retire_t         exp_q [$];
    logic [31:0]     lcg_state;
    int              error_count;
    int              n_retired;
    int              cycle_count;
    int              cycle_limit;

    mini_core #(
        .BOOT_ADDR ( 32'h0 )
    ) i_dut (
        .clk_i            ( clk_i ),
        .rstn_i           ( rstn_i ),
        .ibus_req_addr_o  ( ibus_req_addr_o ),
        .ibus_req_valid_o ( ibus_req_valid_o ),
        .ibus_req_ready_i ( ibus_req_ready_i ),
        .ibus_rsp_data_i  ( ibus_rsp_data_i ),
        .ibus_rsp_valid_i ( ibus_rsp_valid_i ),
        .ibus_rsp_ready_o ( ibus_rsp_ready_o ),
        .retire_valid_o   ( retire_valid_o ),
        .retire_o         ( retire_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // delay of 0 to 3 cycles from the upper lcg bits
    function automatic int unsigned rand_delay();
        logic [31:0] r;
        r = lcg_next();
        return r[17:16];
    endfunction

    // words outside the model decode as illegal
    function automatic logic [XLEN-1:0] read_word(logic [XLEN-1:0] addr);
        if (addr[XLEN-1:2] < MEM_WORDS) begin
            return mem[addr[XLEN-1:2]];
        end
        return '0;
    endfunction

    task automatic load_cases();
        int          fd;
        int          c;
        int          n;
        logic [31:0] f0, f1, f2, f3, f4;
        retire_t     rec;
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = '0;
        end
        fd = $fopen("sim/core_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/core_cases.txt");
            error_count++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);
                end
            end else if (c == "P") begin
                n = $fscanf(fd, "%h %h", f0, f1);
                if (n == 2 && f0 < MEM_WORDS) begin
                    mem[f0] = f1;
                end
            end else if (c == "E") begin
                n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                if (n != 5) begin
                    $display("malformed expected record in sim/core_cases.txt");
                    error_count++;
                end
                rec.pc      = f0;
                rec.rd      = f1[REG_ADDR_W-1:0];
                rec.wdata   = f2;
                rec.we      = f3[0];
                rec.illegal = f4[0];
                exp_q.push_back(rec);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (exp_q.size() == 0) begin
            $display("no expected retire records were found");
            error_count++;
        end
    endtask

    task automatic field_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("[FAIL] %0t ns: retire %0d field %s is %h, expected %h",
                 $time, n_retired, name, got, exp);
        error_count++;
    endtask

    // one clock with no retire expected
    task automatic idle_cycle();
        @(negedge clk_i);
        if (retire_valid_o !== 1'b0) begin
            $display("[FAIL] %0t ns: retire_valid_o high without a response", $time);
            error_count++;
        end
    endtask

    task automatic check_retire();
        retire_t exp_rec;
        if (retire_valid_o !== 1'b1) begin
            $display("no retire pulse followed the response at %0t ns", $time);
            error_count++;
            return;
        end
        exp_rec = exp_q[n_retired];
        if (retire_o.pc !== exp_rec.pc) begin
            field_mismatch("pc", retire_o.pc, exp_rec.pc);
        end
        if (retire_o.rd !== exp_rec.rd) begin
            field_mismatch("rd", 32'(retire_o.rd), 32'(exp_rec.rd));
        end
        if (retire_o.wdata !== exp_rec.wdata) begin
            field_mismatch("wdata", retire_o.wdata, exp_rec.wdata);
        end
        if (retire_o.we !== exp_rec.we) begin
            field_mismatch("we", 32'(retire_o.we), 32'(exp_rec.we));
        end
        if (retire_o.illegal !== exp_rec.illegal) begin
            field_mismatch("illegal", 32'(retire_o.illegal), 32'(exp_rec.illegal));
        end
        n_retired++;
    endtask

    // memory side of one fetch with random delays on both channels
    task automatic serve_fetch();
        logic [XLEN-1:0] addr;
        int unsigned     wait_n;
        while (ibus_req_valid_o !== 1'b1) begin
            idle_cycle();
        end
        addr   = ibus_req_addr_o;
        wait_n = rand_delay();
        repeat (wait_n) idle_cycle();
        ibus_req_ready_i = 1'b1;
        idle_cycle();
        ibus_req_ready_i = 1'b0;
        wait_n = rand_delay();
        repeat (wait_n) idle_cycle();
        ibus_rsp_data_i  = read_word(addr);
        ibus_rsp_valid_i = 1'b1;
        while (ibus_rsp_ready_o !== 1'b1) begin
            idle_cycle();
        end
        // transfer on the next rising edge makes the retire visible
        @(negedge clk_i);
        ibus_rsp_valid_i = 1'b0;
        ibus_rsp_data_i  = '0;
        check_retire();
        if (ibus_req_valid_o !== 1'b1) begin
            $display("[FAIL] %0t ns: no new request on the cycle after the response",
                     $time);
            error_count++;
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles before all instructions retired",
                     cycle_count);
            $display("errors: %0d, retired %0d of %0d", error_count, n_retired,
                     exp_q.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rstn_i           = 1'b0;
        ibus_req_ready_i = 1'b0;
        ibus_rsp_data_i  = '0;
        ibus_rsp_valid_i = 1'b0;
        lcg_state        = 32'haeb1_5005;
        error_count      = 0;
        n_retired        = 0;
        cycle_count      = 0;
        load_cases();
        cycle_limit = exp_q.size() * 12 + 100;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // idle core asks for the boot address first
        if (ibus_req_valid_o !== 1'b1 || ibus_req_addr_o !== 32'h0) begin
            $display("[FAIL] %0t ns: first request valid %b addr %h, expected 1 and 0",
                     $time, ibus_req_valid_o, ibus_req_addr_o);
            error_count++;
        end
        if (ibus_rsp_ready_o !== 1'b0 || retire_valid_o !== 1'b0) begin
            $display("[FAIL] %0t ns: rsp_ready or retire_valid not low after reset",
                     $time);
            error_count++;
        end

        while (n_retired < exp_q.size()) begin
            serve_fetch();
        end

        $display("errors: %0d, retired %0d of %0d", error_count, n_retired,
                 exp_q.size());
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/mini_core.sv
sim/tb_mini_core.sv
